/* src/board_pkg.sv */
// Board I/O subsystem shared types
// Bus word and address types, register map and FSM state encodings
package board_pkg;

	// One data word on the core bus and in memory
	typedef logic [31:0] word_t;

	// Core bus word address
	typedef logic [9:0] addr_t;

	// Data memory address width, 256 words
	localparam int MEM_AW = 8;

	// Start of register space, memory mirrored below it
	localparam addr_t IO_BASE = 10'h200;

	// Register offsets from IO_BASE
	typedef enum logic [1:0] {
		REG_LED   = 2'd0,	// r/w, bits 3:0
		REG_INPUT = 2'd1,	// ro, debounced buttons and switches
		REG_INT   = 2'd2,	// enable on write, pending on read
		REG_DUMP  = 2'd3	// dump start on write, busy on read
	} reg_sel_e;

	// Serial transmitter states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// Memory dump sequencer states
	typedef enum logic [1:0] {
		DUMP_IDLE,
		DUMP_READ,
		DUMP_SEND,
		DUMP_WAIT
	} dump_state_e;

endpackage

/* src/btn_debounce.sv */
// Button and switch debouncer
// Synchronizes each input bit and passes it on once it has held steady
`timescale 1ns/1ps

module btn_debounce #(
	parameter int WIDTH     = 7,
	parameter int DB_CYCLES = 500000
) (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] raw,
	output logic [WIDTH-1:0] db
);

	// Counter must reach DB_CYCLES-1
	localparam int CW = $clog2(DB_CYCLES + 1);

	logic [WIDTH-1:0] sync_a;
	logic [WIDTH-1:0] sync_b;
	logic [CW-1:0]    cnt [WIDTH];

	// Two-flop synchronizer, raw pins are asynchronous
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= raw;
			sync_b <= sync_a;
		end
	end

	// One stability counter per bit
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			db <= '0;
			for (int i = 0; i < WIDTH; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < WIDTH; i++) begin
				if (sync_b[i] == db[i]) begin
					// Input agrees with output, nothing pending
					cnt[i] <= '0;
				end else if (cnt[i] == CW'(DB_CYCLES - 1)) begin
					// Held long enough, accept the new level
					db[i]  <= sync_b[i];
					cnt[i] <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

/* src/data_mem.sv */
// Data memory, 256 words
// Core read/write port A and dump read-only port B, both reads registered
`timescale 1ns/1ps

module data_mem (
	input  logic                        CLK,
	// Port A, core side
	input  logic [board_pkg::MEM_AW-1:0] a_addr,
	input  board_pkg::word_t             a_wdata,
	input  logic                        a_we,
	output board_pkg::word_t             a_rdata,
	// Port B, dump engine side
	input  logic [board_pkg::MEM_AW-1:0] b_addr,
	output board_pkg::word_t             b_rdata
);

	localparam int DEPTH = 2 ** board_pkg::MEM_AW;

	// Storage array, maps onto block RAM
	board_pkg::word_t mem [DEPTH];

	// Port A, write plus read-before-write
	always_ff @(posedge CLK) begin
		if (a_we) begin
			mem[a_addr] <= a_wdata;
		end
		a_rdata <= mem[a_addr];
	end

	// Port B, read only
	always_ff @(posedge CLK) begin
		b_rdata <= mem[b_addr];
	end

endmodule

/* src/bus_regs.sv */
// Core bus decoder and I/O register block
// LED, input status, interrupt enable/pending and dump control registers
`timescale 1ns/1ps

module bus_regs (
	input  logic                         CLK,
	input  logic                         rst_n,
	// Core bus
	input  board_pkg::addr_t              addr,
	input  board_pkg::word_t              wdata,
	input  logic                         we,
	output board_pkg::word_t              rdata,
	// Debounced buttons 3:0 and switches 6:4
	input  logic [6:0]                   db_in,
	output logic [3:0]                   led,
	output logic                         int_sig,
	// Data memory port A
	output logic [board_pkg::MEM_AW-1:0] mem_addr,
	output board_pkg::word_t              mem_wdata,
	output logic                         mem_we,
	input  board_pkg::word_t              mem_rdata,
	// Dump engine control
	output logic                         dump_start,
	output logic [8:0]                   dump_count,
	input  logic                         dump_busy
);

	logic                io_sel;
	logic                io_we;
	board_pkg::reg_sel_e sel;
	logic [6:0]          int_en;
	logic [6:0]          int_pend;
	logic [6:0]          int_clr;
	logic [6:0]          db_prev;
	logic                start_ok;
	board_pkg::word_t    reg_rdata;
	board_pkg::word_t    reg_rdata_q;
	logic                rd_io_q;

	// Address decode, memory below IO_BASE
	assign io_sel = (addr >= board_pkg::IO_BASE);
	assign io_we  = we && io_sel;
	assign sel    = board_pkg::reg_sel_e'(addr[1:0]);

	// Memory mirrored on the low address bits
	assign mem_addr  = addr[board_pkg::MEM_AW-1:0];
	assign mem_wdata = wdata;
	assign mem_we    = we && !io_sel;

	// Write ones at 22:16 of REG_INT to clear pending
	assign int_clr = (io_we && sel == board_pkg::REG_INT) ? wdata[22:16] : 7'd0;

	// Start only with a nonzero count and an idle engine
	assign start_ok = io_we && (sel == board_pkg::REG_DUMP) && (wdata[8:0] != 9'd0)
		&& !dump_busy;

	// Register read mux
	always_comb begin
		reg_rdata = '0;
		case (sel)
			board_pkg::REG_LED:   reg_rdata[3:0] = led;
			board_pkg::REG_INPUT: reg_rdata[6:0] = db_in;
			board_pkg::REG_INT:   reg_rdata[6:0] = int_pend;
			board_pkg::REG_DUMP:  reg_rdata[0]   = dump_busy;
			default:              reg_rdata      = '0;
		endcase
	end

	// Control registers
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			led        <= '0;
			int_en     <= '0;
			int_pend   <= '0;
			db_prev    <= '0;
			int_sig    <= 1'b0;
			dump_start <= 1'b0;
			rd_io_q    <= 1'b0;
		end else begin
			if (io_we && sel == board_pkg::REG_LED) begin
				led <= wdata[3:0];
			end
			if (io_we && sel == board_pkg::REG_INT) begin
				int_en <= wdata[6:0];
			end
			// Any edge on an input sets its pending bit, set wins over clear
			db_prev  <= db_in;
			int_pend <= (int_pend & ~int_clr) | (db_in ^ db_prev);
			int_sig  <= |(int_pend & int_en);
			dump_start <= start_ok;
			// Remember read source to line up with memory latency
			rd_io_q <= io_sel;
		end
	end

	// Payload registers
	always_ff @(posedge CLK) begin
		reg_rdata_q <= reg_rdata;
		if (start_ok) begin
			dump_count <= wdata[8:0];
		end
	end

	assign rdata = rd_io_q ? reg_rdata_q : mem_rdata;

endmodule

/* src/uart_tx.sv */
// UART transmitter, 8N1
// Start bit, eight data bits LSB first, one stop bit at a fixed bit period
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_start,
	output logic       tx_busy,
	output logic       line
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	board_pkg::tx_state_e state;
	logic [CW-1:0]        cnt;
	logic [2:0]           bit_idx;
	logic [7:0]           shreg;
	logic                 bit_end;

	// Last cycle of the current bit period
	assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));

	assign tx_busy = (state != board_pkg::TX_IDLE);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state   <= board_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			shreg   <= '0;
			line    <= 1'b1;
		end else begin
			case (state)
				board_pkg::TX_IDLE: begin
					line <= 1'b1;
					cnt  <= '0;
					if (tx_start) begin
						// Latch the byte and pull the line low for start
						shreg <= tx_data;
						line  <= 1'b0;
						state <= board_pkg::TX_START;
					end
				end
				board_pkg::TX_START: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= '0;
						line    <= shreg[0];
						shreg   <= shreg >> 1;
						state   <= board_pkg::TX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				board_pkg::TX_DATA: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							// Stop bit
							line  <= 1'b1;
							state <= board_pkg::TX_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							line    <= shreg[0];
							shreg   <= shreg >> 1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				board_pkg::TX_STOP: begin
					if (bit_end) begin
						cnt   <= '0;
						state <= board_pkg::TX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= board_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

/* src/mem_dump.sv */
// Memory dump engine
// Reads words from address 0 and sends each as four bytes, LSB first, over UART
`timescale 1ns/1ps

module mem_dump (
	input  logic                         CLK,
	input  logic                         rst_n,
	input  logic                         dump_start,
	input  logic [8:0]                   dump_count,
	output logic                         dump_busy,
	output logic [board_pkg::MEM_AW-1:0] dump_addr,
	input  board_pkg::word_t              dump_rdata,
	output logic [7:0]                   tx_data,
	output logic                         tx_start,
	input  logic                         tx_busy
);

	board_pkg::dump_state_e       state;
	logic [board_pkg::MEM_AW-1:0] addr_q;
	logic [8:0]                   words_left;
	logic [1:0]                   byte_idx;
	logic                         rd_wait;
	board_pkg::word_t             word_q;

	assign dump_busy = (state != board_pkg::DUMP_IDLE);
	assign dump_addr = addr_q;

	// Byte select, LSB first
	assign tx_data  = word_q[byte_idx*8 +: 8];
	// Hand off only when the transmitter is free
	assign tx_start = (state == board_pkg::DUMP_SEND) && !tx_busy;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state      <= board_pkg::DUMP_IDLE;
			addr_q     <= '0;
			words_left <= '0;
			byte_idx   <= '0;
			rd_wait    <= 1'b0;
		end else begin
			case (state)
				board_pkg::DUMP_IDLE: begin
					if (dump_start) begin
						addr_q     <= '0;
						words_left <= dump_count;
						rd_wait    <= 1'b0;
						state      <= board_pkg::DUMP_READ;
					end
				end
				board_pkg::DUMP_READ: begin
					// First cycle issues the read, second takes the data
					rd_wait <= !rd_wait;
					if (rd_wait) begin
						byte_idx <= '0;
						state    <= board_pkg::DUMP_SEND;
					end
				end
				board_pkg::DUMP_SEND: begin
					if (!tx_busy) begin
						state <= board_pkg::DUMP_WAIT;
					end
				end
				board_pkg::DUMP_WAIT: begin
					// Transmitter went busy on the accept edge, wait for the stop bit
					if (!tx_busy) begin
						if (byte_idx != 2'd3) begin
							byte_idx <= byte_idx + 1'b1;
							state    <= board_pkg::DUMP_SEND;
						end else if (words_left == 9'd1) begin
							words_left <= '0;
							state      <= board_pkg::DUMP_IDLE;
						end else begin
							words_left <= words_left - 1'b1;
							addr_q     <= addr_q + 1'b1;
							rd_wait    <= 1'b0;
							state      <= board_pkg::DUMP_READ;
						end
					end
				end
				default: state <= board_pkg::DUMP_IDLE;
			endcase
		end
	end

	// Word latch
	always_ff @(posedge CLK) begin
		if (state == board_pkg::DUMP_READ && rd_wait) begin
			word_q <= dump_rdata;
		end
	end

endmodule

/* src/io_top.sv */
// Board I/O subsystem top level
// Connects debouncer, registers, memory, dump engine and UART to pins and core bus
`timescale 1ns/1ps

module io_top #(
	parameter int DB_CYCLES    = 500000,
	parameter int CLKS_PER_BIT = 434
) (
	input  logic             CLK,
	input  logic             rst_n,
	// Board pins
	input  logic [3:0]       btn,
	input  logic [2:0]       sw,
	output logic [3:0]       led,
	output logic             int_sig,
	output logic             uart_tx,
	// Core data bus
	input  board_pkg::addr_t addr,
	input  board_pkg::word_t wdata,
	input  logic             we,
	output board_pkg::word_t rdata
);

	logic [6:0]                   db_in;
	// Memory port A from the register block
	logic [board_pkg::MEM_AW-1:0] mem_addr;
	board_pkg::word_t             mem_wdata;
	logic                         mem_we;
	board_pkg::word_t             mem_rdata;
	// Dump control and memory port B
	logic                         dump_start;
	logic [8:0]                   dump_count;
	logic                         dump_busy;
	logic [board_pkg::MEM_AW-1:0] dump_addr;
	board_pkg::word_t             dump_rdata;
	// Byte hand-off to the transmitter
	logic [7:0]                   tx_data;
	logic                         tx_start;
	logic                         tx_busy;

	// Switches on the upper bits, buttons on the lower
	btn_debounce #(
		.WIDTH     (7),
		.DB_CYCLES (DB_CYCLES)
	) u_debounce (
		.CLK   (CLK),
		.rst_n (rst_n),
		.raw   ({sw, btn}),
		.db    (db_in)
	);

	bus_regs u_regs (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.addr       (addr),
		.wdata      (wdata),
		.we         (we),
		.rdata      (rdata),
		.db_in      (db_in),
		.led        (led),
		.int_sig    (int_sig),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_we     (mem_we),
		.mem_rdata  (mem_rdata),
		.dump_start (dump_start),
		.dump_count (dump_count),
		.dump_busy  (dump_busy)
	);

	data_mem u_mem (
		.CLK     (CLK),
		.a_addr  (mem_addr),
		.a_wdata (mem_wdata),
		.a_we    (mem_we),
		.a_rdata (mem_rdata),
		.b_addr  (dump_addr),
		.b_rdata (dump_rdata)
	);

	mem_dump u_dump (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.dump_start (dump_start),
		.dump_count (dump_count),
		.dump_busy  (dump_busy),
		.dump_addr  (dump_addr),
		.dump_rdata (dump_rdata),
		.tx_data    (tx_data),
		.tx_start   (tx_start),
		.tx_busy    (tx_busy)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.line     (uart_tx)
	);

endmodule

/* tests/tb_io_top.sv */
// Testbench for the board I/O subsystem
// Acts as the core on the bus, drives buttons and switches and receives the UART stream
`timescale 1ns/1ps

module tb_io_top;

	localparam int DB_CYCLES    = 4;
	localparam int CLKS_PER_BIT = 8;
	localparam int NUM_WORDS    = 16;

	logic             CLK;
	logic             rst_n;
	logic [3:0]       btn;
	logic [2:0]       sw;
	logic [3:0]       led;
	logic             int_sig;
	logic             uart_tx;
	board_pkg::addr_t addr;
	board_pkg::word_t wdata;
	logic             we;
	board_pkg::word_t rdata;

	// Words written by the memory test, the dump test sends them back
	board_pkg::word_t exp_mem [NUM_WORDS];
	logic [15:0]      lfsr_q;

	io_top #(
		.DB_CYCLES    (DB_CYCLES),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_dut (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.btn     (btn),
		.sw      (sw),
		.led     (led),
		.int_sig (int_sig),
		.uart_tx (uart_tx),
		.addr    (addr),
		.wdata   (wdata),
		.we      (we),
		.rdata   (rdata)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic board_pkg::addr_t reg_addr(input board_pkg::reg_sel_e r);
		return board_pkg::IO_BASE | board_pkg::addr_t'(r);
	endfunction

	task automatic check_word(input string name, input board_pkg::word_t got,
		input board_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		$display("Errors found");
		$fatal(1);
	endtask

	// Write takes effect on the edge where we is high
	task automatic bus_write(input board_pkg::addr_t a, input board_pkg::word_t d);
		@(posedge CLK);
		addr  <= a;
		wdata <= d;
		we    <= 1'b1;
		@(posedge CLK);
		we <= 1'b0;
	endtask

	// One cycle read latency, sample mid-cycle
	task automatic bus_read(input board_pkg::addr_t a, output board_pkg::word_t d);
		@(posedge CLK);
		addr <= a;
		we   <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);
		d = rdata;
	endtask

	task automatic expect_read(input board_pkg::addr_t a, input board_pkg::word_t exp,
		input string name);
		board_pkg::word_t v;
		bus_read(a, v);
		check_word(name, v, exp);
	endtask

	task automatic set_inputs(input logic [3:0] btn_v, input logic [2:0] sw_v);
		@(posedge CLK);
		btn <= btn_v;
		sw  <= sw_v;
	endtask

	// 8N1 receiver, samples each bit in its middle
	task automatic uart_recv_byte(output logic [7:0] data);
		int   n;
		logic seen;
		seen = 1'b0;
		data = '0;
		for (n = 0; n < 400 && !seen; n++) begin
			@(negedge CLK);
			seen = (uart_tx == 1'b0);
		end
		if (!seen) begin
			report_timeout("a UART start bit");
		end
		repeat (CLKS_PER_BIT / 2) @(negedge CLK);
		check_bit("uart_tx start bit", uart_tx, 1'b0);
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			data[i] = uart_tx;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		check_bit("uart_tx stop bit", uart_tx, 1'b1);
	endtask

	task automatic test_reset();
		@(negedge CLK);
		check_bit("uart_tx", uart_tx, 1'b1);
		check_bit("int_sig", int_sig, 1'b0);
		check_byte("led", {4'b0, led}, 8'h00);
		expect_read(reg_addr(board_pkg::REG_INPUT), '0, "rdata REG_INPUT");
		expect_read(reg_addr(board_pkg::REG_INT), '0, "rdata REG_INT");
		expect_read(reg_addr(board_pkg::REG_DUMP), '0, "rdata REG_DUMP");
	endtask

	task automatic test_memory();
		for (int i = 0; i < NUM_WORDS; i++) begin
			exp_mem[i] = lfsr_bits(32);
			bus_write(board_pkg::addr_t'(i), exp_mem[i]);
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			expect_read(board_pkg::addr_t'(i), exp_mem[i], "rdata memory");
		end
	endtask

	task automatic test_led();
		logic [3:0] v;
		v = 4'(lfsr_bits(4));
		// Value and its inverse so every pin toggles
		for (int k = 0; k < 2; k++) begin
			bus_write(reg_addr(board_pkg::REG_LED), {28'b0, v});
			@(negedge CLK);
			check_byte("led", {4'b0, led}, {4'b0, v});
			expect_read(reg_addr(board_pkg::REG_LED), {28'b0, v}, "rdata REG_LED");
			v = ~v;
		end
	endtask

	task automatic test_inputs();
		board_pkg::word_t v;
		// Pulse of 2 cycles, shorter than the stability count
		set_inputs(4'b0001, 3'b000);
		@(posedge CLK);
		set_inputs(4'b0000, 3'b000);
		// Keep reading through the window where an unfiltered pulse would show
		for (int n = 0; n < 2 * DB_CYCLES; n++) begin
			expect_read(reg_addr(board_pkg::REG_INPUT), '0, "rdata REG_INPUT after pulse");
		end
		expect_read(reg_addr(board_pkg::REG_INT), '0, "rdata REG_INT after pulse");
		// Held level
		set_inputs(4'b0010, 3'b101);
		v = '0;
		for (int n = 0; n < 50 && v != 32'h52; n++) begin
			bus_read(reg_addr(board_pkg::REG_INPUT), v);
		end
		if (v != 32'h52) begin
			report_timeout("REG_INPUT to follow the held inputs");
		end
		expect_read(reg_addr(board_pkg::REG_INT), 32'h52, "rdata REG_INT pending");
		check_bit("int_sig with nothing enabled", int_sig, 1'b0);
		// Bit 0 enabled but not pending
		bus_write(reg_addr(board_pkg::REG_INT), 32'h01);
		@(posedge CLK);
		@(negedge CLK);
		check_bit("int_sig with other bit enabled", int_sig, 1'b0);
		bus_write(reg_addr(board_pkg::REG_INT), 32'h02);
		@(posedge CLK);
		@(negedge CLK);
		check_bit("int_sig enabled", int_sig, 1'b1);
		// Clear all pending bits, keep the enable
		bus_write(reg_addr(board_pkg::REG_INT), 32'h0052_0002);
		@(posedge CLK);
		@(negedge CLK);
		check_bit("int_sig after clear", int_sig, 1'b0);
		expect_read(reg_addr(board_pkg::REG_INT), '0, "rdata REG_INT after clear");
	endtask

	task automatic test_dump();
		logic [7:0]       b;
		board_pkg::word_t v;
		bus_write(reg_addr(board_pkg::REG_DUMP), 32'd3);
		fork
			begin
				for (int w = 0; w < 3; w++) begin
					for (int k = 0; k < 4; k++) begin
						uart_recv_byte(b);
						check_byte("uart byte", b, exp_mem[w][8*k +: 8]);
					end
				end
			end
			begin
				expect_read(reg_addr(board_pkg::REG_DUMP), 32'd1, "rdata REG_DUMP busy");
				// Second start while busy
				bus_write(reg_addr(board_pkg::REG_DUMP), 32'd5);
				expect_read(reg_addr(board_pkg::REG_DUMP), 32'd1, "rdata REG_DUMP still busy");
			end
		join
		v = 32'd1;
		for (int n = 0; n < 100 && v != 0; n++) begin
			bus_read(reg_addr(board_pkg::REG_DUMP), v);
		end
		if (v != 0) begin
			report_timeout("REG_DUMP busy to clear");
		end
		// Line must stay idle, no extra bytes
		repeat (CLKS_PER_BIT * 40) begin
			@(negedge CLK);
			check_bit("uart_tx idle after dump", uart_tx, 1'b1);
		end
	endtask

	initial begin
		rst_n  = 1'b0;
		btn    = '0;
		sw     = '0;
		addr   = '0;
		wdata  = '0;
		we     = 1'b0;
		lfsr_q = 16'd66;
		repeat (10) @(posedge CLK);
		rst_n <= 1'b1;
		test_reset();
		test_memory();
		test_led();
		test_inputs();
		test_dump();
		$display("No errors");
		$finish;
	end

endmodule

/* vlog.f */
src/board_pkg.sv
src/btn_debounce.sv
src/data_mem.sv
src/bus_regs.sv
src/uart_tx.sv
src/mem_dump.sv
src/io_top.sv
tests/tb_io_top.sv

/* Makefile */
# Verilator lint and simulation for the board I/O subsystem

VERILATOR = verilator
FLAGS     = --timing --timescale 1ns/1ps
TOP       = tb_io_top
LINT_TOP  = io_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail
sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
